//--- rvPkg.sv
/*
  ISA-level widths and CSR addresses for an RV64 execute stage.
  Only the four machine-mode CSRs listed here are implemented,
  all other addresses read as zero.
*/
package rvPkg;

    // data and address words
    typedef logic [63:0] xlenT;

    // register index
    typedef logic [4:0] regAddrT;

    // csr address, taken from imm[11:0]
    typedef logic [11:0] csrAddrT;

    // wishbone byte lanes of a 64-bit bus
    typedef logic [7:0] byteSelT;

    // machine-mode csrs
    localparam csrAddrT CSR_MSCRATCH = 12'h340;
    localparam csrAddrT CSR_MEPC     = 12'h341;
    localparam csrAddrT CSR_MCAUSE   = 12'h342;
    localparam csrAddrT CSR_MTVEC    = 12'h305;

    // x0 included
    localparam int NUM_REGS = 32;

endpackage

//--- exuCtrlPkg.sv
/*
  Decoded control encodings driven by the decoder into the execute stage,
  and the state encoding of the load/store unit.
  Word variants and mul/div are not encoded.
*/
package exuCtrlPkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } aluOpT;

    // second alu operand
    typedef enum logic [1:0] {
        SRCB_REG,
        SRCB_IMM,
        SRCB_FOUR
    } aluSrcBT;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_JAL,
        BR_JALR,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE
    } branchT;

    // loads first, then stores
    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB, MEM_LH, MEM_LW, MEM_LD,
        MEM_LBU, MEM_LHU, MEM_LWU,
        MEM_SB, MEM_SH, MEM_SW, MEM_SD
    } memOpT;

    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } csrOpT;

    typedef enum logic {
        LSU_IDLE,
        LSU_BUSY
    } lsuStateT;

endpackage

//--- regFile.sv
/*
  Integer register file, two asynchronous reads and one write port.
  x0 reads zero and ignores writes.
*/
module regFile import rvPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  regAddrT raAddr,
    input  regAddrT rbAddr,
    input  regAddrT wAddr,
    input  xlenT    wData,
    input  logic    wEn,
    output xlenT    raData,
    output xlenT    rbData
);

    xlenT regs [NUM_REGS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wEn && (wAddr != '0)) begin
            regs[wAddr] <= wData;
        end
    end

    // x0 forced on the read side as well
    assign raData = (raAddr == '0) ? '0 : regs[raAddr];
    assign rbData = (rbAddr == '0) ? '0 : regs[rbAddr];

endmodule

//--- csrFile.sv
/*
  Machine-mode CSRs: mscratch, mepc, mcause and mtvec.
  Unknown addresses read zero and drop writes. csrRes is the value
  before the update, written back on commit.
*/
module csrFile import rvPkg::*, exuCtrlPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  csrOpT   csrOp,
    input  csrAddrT csrAddr,
    input  xlenT    dataIn,
    input  logic    commit,
    output xlenT    csrRes,
    output xlenT    mepc
);

    xlenT mscratchQ;
    xlenT mepcQ;
    xlenT mcauseQ;
    xlenT mtvecQ;
    xlenT newVal;

    always_comb begin
        case (csrAddr)
            CSR_MSCRATCH: csrRes = mscratchQ;
            CSR_MEPC:     csrRes = mepcQ;
            CSR_MCAUSE:   csrRes = mcauseQ;
            CSR_MTVEC:    csrRes = mtvecQ;
            default:      csrRes = '0;
        endcase
    end

    always_comb begin
        case (csrOp)
            CSR_WRITE: newVal = dataIn;
            CSR_SET:   newVal = csrRes | dataIn;
            CSR_CLEAR: newVal = csrRes & ~dataIn;
            default:   newVal = csrRes;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mscratchQ <= '0;
            mepcQ     <= '0;
            mcauseQ   <= '0;
            mtvecQ    <= '0;
        end else if (commit && (csrOp != CSR_NONE)) begin
            case (csrAddr)
                CSR_MSCRATCH: mscratchQ <= newVal;
                CSR_MEPC:     mepcQ     <= newVal;
                CSR_MCAUSE:   mcauseQ   <= newVal;
                CSR_MTVEC:    mtvecQ    <= newVal;
                default: begin
                end
            endcase
        end
    end

    // return address for mret
    assign mepc = mepcQ;

endmodule

//--- alu.sv
/*
  64-bit integer ALU. Shift amount is inB[5:0].
  slt/sltu produce 0 or 1; zero flags an all-zero result,
  which beq/bne read from a subtraction.
*/
module alu import rvPkg::*, exuCtrlPkg::*; (
    input  xlenT  inA,
    input  xlenT  inB,
    input  aluOpT aluOp,
    output xlenT  result,
    output logic  zero
);

    logic [5:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = inB[5:0];
    assign lessSigned   = $signed(inA) < $signed(inB);
    assign lessUnsigned = inA < inB;

    always_comb begin
        case (aluOp)
            ALU_ADD:  result = inA + inB;
            ALU_SUB:  result = inA - inB;
            ALU_AND:  result = inA & inB;
            ALU_OR:   result = inA | inB;
            ALU_XOR:  result = inA ^ inB;
            ALU_SLL:  result = inA << shamt;
            ALU_SRL:  result = inA >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  result = xlenT'($signed(inA) >>> shamt);
            ALU_SLT:  result = {63'b0, lessSigned};
            ALU_SLTU: result = {63'b0, lessUnsigned};
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- nextPc.sv
/*
  Next-pc calculation. Branch conditions come from the ALU flags,
  so the decoder must select sub for beq/bne and slt for blt/bge.
  mret returns to mepc. Bit 0 is cleared by the caller.
*/
module nextPc import rvPkg::*, exuCtrlPkg::*; (
    input  branchT branch,
    input  logic   zero,
    input  logic   res0,
    input  xlenT   pc,
    input  xlenT   imm,
    input  xlenT   rs1Val,
    input  xlenT   mepc,
    input  logic   mret,
    output xlenT   target
);

    logic useRs1;
    logic useImm;
    xlenT base;
    xlenT offset;

    always_comb begin
        useRs1 = 1'b0;
        case (branch)
            BR_JAL:  useImm = 1'b1;
            BR_JALR: begin
                useRs1 = 1'b1;
                useImm = 1'b1;
            end
            BR_BEQ:  useImm = zero;
            BR_BNE:  useImm = ~zero;
            BR_BLT:  useImm = res0;
            BR_BGE:  useImm = ~res0;
            default: useImm = 1'b0;
        endcase
    end

    assign base   = useRs1 ? rs1Val : pc;
    assign offset = useImm ? imm : 64'd4;
    assign target = mret ? mepc : (base + offset);

endmodule

//--- lsuWishbone.sv
/*
  Wishbone classic data master, one access at a time.
  Addresses are assumed naturally aligned; no fault or misalign checks.
  done and loadData are valid in the ack cycle, combinationally from wbDatR.
  Request fields are captured on start, so the issue side may move on.
*/
module lsuWishbone import rvPkg::*, exuCtrlPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    start,
    input  memOpT   memOp,
    input  xlenT    addr,
    input  xlenT    storeData,
    input  xlenT    wbDatR,
    input  logic    wbAck,
    output logic    busy,
    output logic    done,
    output xlenT    loadData,
    output logic    wbCyc,
    output logic    wbStb,
    output logic    wbWe,
    output xlenT    wbAdr,
    output byteSelT wbSel,
    output xlenT    wbDatW
);

    lsuStateT   state;
    memOpT      memOpQ;
    logic [2:0] offsetQ;
    logic       weQ;
    byteSelT    sizeMask;
    xlenT       lane;

    // bytes touched, before the lane shift
    always_comb begin
        case (memOp)
            MEM_LB, MEM_LBU, MEM_SB: sizeMask = 8'h01;
            MEM_LH, MEM_LHU, MEM_SH: sizeMask = 8'h03;
            MEM_LW, MEM_LWU, MEM_SW: sizeMask = 8'h0f;
            default:                 sizeMask = 8'hff;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= LSU_IDLE;
        end else begin
            case (state)
                LSU_IDLE: if (start) state <= LSU_BUSY;
                LSU_BUSY: if (wbAck) state <= LSU_IDLE;
                default:  state <= LSU_IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (start && (state == LSU_IDLE)) begin
            memOpQ  <= memOp;
            offsetQ <= addr[2:0];
            weQ     <= memOp inside {MEM_SB, MEM_SH, MEM_SW, MEM_SD};
            wbAdr   <= {addr[63:3], 3'b000};
            wbSel   <= sizeMask << addr[2:0];
            wbDatW  <= storeData << {addr[2:0], 3'b000};
        end
    end

    assign busy  = (state == LSU_BUSY);
    assign wbCyc = busy;
    assign wbStb = busy;
    assign wbWe  = busy & weQ;
    assign done  = busy & wbAck;

    // addressed lane moved down to bit 0
    assign lane = wbDatR >> {offsetQ, 3'b000};

    always_comb begin
        case (memOpQ)
            MEM_LB:  loadData = {{56{lane[7]}}, lane[7:0]};
            MEM_LH:  loadData = {{48{lane[15]}}, lane[15:0]};
            MEM_LW:  loadData = {{32{lane[31]}}, lane[31:0]};
            MEM_LBU: loadData = {56'b0, lane[7:0]};
            MEM_LHU: loadData = {48'b0, lane[15:0]};
            MEM_LWU: loadData = {32'b0, lane[31:0]};
            default: loadData = lane;
        endcase
    end

endmodule

//--- exuTop.sv
/*
  RV64 execute stage. Takes one pre-decoded op per valid/ready handshake.
  Non-memory ops commit on the accept edge; memory ops commit on the ack
  edge. retire pulses and dnpc is valid in the cycle after commit.
  Fetch, decode, interrupts and access faults are not handled here.
*/
module exuTop import rvPkg::*, exuCtrlPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    opValid,
    input  regAddrT rd,
    input  regAddrT rs1,
    input  regAddrT rs2,
    input  logic    regWen,
    input  logic    aluSrcA,
    input  aluSrcBT aluSrcB,
    input  aluOpT   aluOp,
    input  branchT  branch,
    input  memOpT   memOp,
    input  csrOpT   csrOp,
    input  logic    csrSrcPc,
    input  logic    csrToReg,
    input  logic    mret,
    input  xlenT    pc,
    input  xlenT    imm,
    output logic    opReady,
    output logic    retire,
    output xlenT    dnpc,
    output logic    wbCyc,
    output logic    wbStb,
    output logic    wbWe,
    output xlenT    wbAdr,
    output byteSelT wbSel,
    output xlenT    wbDatW,
    input  xlenT    wbDatR,
    input  logic    wbAck
);

    logic    accept;
    logic    isMem;
    logic    commitNow;
    logic    memStart;
    logic    lsuBusy;
    logic    lsuDone;
    logic    aluZero;
    logic    loadWenQ;
    xlenT    raData;
    xlenT    rbData;
    xlenT    aluInA;
    xlenT    aluInB;
    xlenT    aluRes;
    xlenT    csrRes;
    xlenT    csrData;
    xlenT    mepc;
    xlenT    target;
    xlenT    npcQ;
    xlenT    loadData;
    regAddrT rdQ;
    regAddrT wAddr;
    xlenT    wData;
    logic    wEn;
    csrAddrT csrAddr;

    assign opReady   = ~lsuBusy;
    assign accept    = opValid & opReady;
    assign isMem     = (memOp != MEM_NONE);
    assign commitNow = accept & ~isMem;
    assign memStart  = accept & isMem;

    assign aluInA = aluSrcA ? raData : pc;
    always_comb begin
        case (aluSrcB)
            SRCB_REG: aluInB = rbData;
            SRCB_IMM: aluInB = imm;
            default:  aluInB = 64'd4;
        endcase
    end

    assign csrAddr = imm[11:0];
    assign csrData = csrSrcPc ? pc : raData;

    // load data lands on the ack edge, op results on the accept edge
    assign wAddr = lsuDone ? rdQ : rd;
    assign wData = lsuDone ? loadData : (csrToReg ? csrRes : aluRes);
    assign wEn   = lsuDone ? loadWenQ : (commitNow & regWen);

    regFile uRegFile (
        .clk(clk), .arstN(arstN),
        .raAddr(rs1), .rbAddr(rs2), .wAddr(wAddr), .wData(wData), .wEn(wEn),
        .raData(raData), .rbData(rbData)
    );

    csrFile uCsrFile (
        .clk(clk), .arstN(arstN), .csrOp(csrOp), .csrAddr(csrAddr),
        .dataIn(csrData), .commit(commitNow), .csrRes(csrRes), .mepc(mepc)
    );

    alu uAlu (.inA(aluInA), .inB(aluInB), .aluOp(aluOp), .result(aluRes), .zero(aluZero));

    nextPc uNextPc (
        .branch(branch), .zero(aluZero), .res0(aluRes[0]), .pc(pc), .imm(imm),
        .rs1Val(raData), .mepc(mepc), .mret(mret), .target(target)
    );

    lsuWishbone uLsu (
        .clk(clk), .arstN(arstN), .start(memStart), .memOp(memOp),
        .addr(aluRes), .storeData(rbData), .wbDatR(wbDatR), .wbAck(wbAck),
        .busy(lsuBusy), .done(lsuDone), .loadData(loadData),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbSel(wbSel), .wbDatW(wbDatW)
    );

    // destination and return pc of the outstanding access
    always_ff @(posedge clk) begin
        if (memStart) begin
            rdQ  <= rd;
            npcQ <= target;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            loadWenQ <= 1'b0;
            retire   <= 1'b0;
            dnpc     <= '0;
        end else begin
            retire <= commitNow | lsuDone;
            if (memStart) begin
                loadWenQ <= regWen & (memOp inside {MEM_LB, MEM_LH, MEM_LW, MEM_LD,
                                                    MEM_LBU, MEM_LHU, MEM_LWU});
            end
            if (commitNow) begin
                dnpc <= {target[63:1], 1'b0};
            end else if (lsuDone) begin
                dnpc <= {npcQ[63:1], 1'b0};
            end
        end
    end

endmodule

//--- exuTb.sv
/*
  Testbench for the execute stage. Ops are issued in order through opValid/opReady.
  Register values are loaded by adding imm 0 to a chosen pc.
  The memory model keeps only the words that are written, the rest read a fill pattern.
  Addresses stay below 4 KB.
*/
module exuTb import rvPkg::*, exuCtrlPkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk, arstN, opValid, regWen, aluSrcA, csrSrcPc, csrToReg, mret, opReady, retire;
    logic wbCyc, wbStb, wbWe, wbAck;
    regAddrT rd, rs1, rs2;
    aluSrcBT aluSrcB;
    aluOpT aluOp;
    branchT branch;
    memOpT memOp;
    csrOpT csrOp;
    xlenT pc, imm, dnpc, wbAdr, wbDatW, wbDatR, tbPc, memWord;
    byteSelT wbSel;
    int ackWait;

    xlenT refRegs [NUM_REGS];
    xlenT refMem [xlenT];
    xlenT modelMem [xlenT];
    xlenT refCsr [csrAddrT];
    xlenT expPcQ [$];
    xlenT stAdrQ [$];
    xlenT stDatQ [$];
    byteSelT stSelQ [$];

    exuTop UUT (.*);

    always #2 clk = ~clk;

    function automatic xlenT fillWord(xlenT wa);
        return {wa[63:32] ^ ~wa[31:0], wa[31:0] ^ 32'hc3a55a3c};
    endfunction

    function automatic xlenT byteMask(byteSelT s);
        xlenT m;
        for (int i = 0; i < 8; i++) m[i*8 +: 8] = {8{s[i]}};
        return m;
    endfunction

    function automatic int accessBytes(memOpT op);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: return 1;
            MEM_LH, MEM_LHU, MEM_SH: return 2;
            MEM_LW, MEM_LWU, MEM_SW: return 4;
            default: return 8;
        endcase
    endfunction

    // reference model of the architectural rules
    function automatic xlenT refAlu(aluOpT op, xlenT a, xlenT b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[5:0];
            ALU_SRL: return a >> b[5:0];
            ALU_SRA: return $signed(a) >>> b[5:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            default: return (a < b) ? 64'd1 : 64'd0;
        endcase
    endfunction

    function automatic xlenT refLoad(memOpT op, xlenT w, logic [2:0] off);
        xlenT v;
        int n;
        n = accessBytes(op);
        v = w >> (off * 8);
        if (n < 8) v = v & ((64'd1 << (n * 8)) - 1);
        if ((op inside {MEM_LB, MEM_LH, MEM_LW}) && v[n*8-1]) v = v | ~((64'd1 << (n * 8)) - 1);
        return v;
    endfunction

    function automatic xlenT refRead(xlenT wa);
        return refMem.exists(wa) ? refMem[wa] : fillWord(wa);
    endfunction

    task automatic reportMismatch(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportTimeout(input string msg);
        $display("Timed out: %s", msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkPc(input xlenT got, input xlenT exp);
        if (got !== exp) reportMismatch($sformatf("dnpc is %h, expected %h", got, exp));
    endtask

    task automatic checkWord(input xlenT got, input xlenT exp, input string what);
        if (got !== exp) reportMismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic checkSel(input byteSelT got, input byteSelT exp);
        if (got !== exp) reportMismatch($sformatf("wbSel is %h, expected %h", got, exp));
    endtask

    // compare process for retires and bus writes
    always @(posedge clk) begin
        xlenT m;
        if (arstN && retire) begin
            if (expPcQ.size() == 0) begin
                reportMismatch("retire with no op outstanding");
            end else begin
                checkPc(dnpc, expPcQ.pop_front());
            end
        end
        if (arstN && wbCyc && wbStb && wbWe && wbAck) begin
            if (stSelQ.size() == 0) begin
                reportMismatch("unexpected bus write");
            end else begin
                m = byteMask(stSelQ[0]);
                checkWord(wbAdr, stAdrQ.pop_front(), "wbAdr");
                checkSel(wbSel, stSelQ.pop_front());
                checkWord(wbDatW & m, stDatQ.pop_front() & m, "wbDatW");
            end
        end
    end

    // memory model, acks after 0 to 3 wait cycles
    always @(posedge clk) begin
        #1;
        if (wbCyc && wbStb && !wbAck) begin
            if (ackWait == 0) begin
                memWord = modelMem.exists(wbAdr) ? modelMem[wbAdr] : fillWord(wbAdr);
                if (wbWe) begin
                    modelMem[wbAdr] = (memWord & ~byteMask(wbSel)) | (wbDatW & byteMask(wbSel));
                end
                wbDatR = memWord;
                wbAck = 1'b1;
            end else begin
                ackWait--;
            end
        end else begin
            wbAck = 1'b0;
            ackWait = $urandom_range(0, 3);
        end
    end

    task automatic clearFields();
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        regWen = 1'b0;
        csrSrcPc = 1'b0;
        csrToReg = 1'b0;
        mret = 1'b0;
        aluSrcA = 1'b1;
        aluSrcB = SRCB_REG;
        aluOp = ALU_ADD;
        branch = BR_NONE;
        memOp = MEM_NONE;
        csrOp = CSR_NONE;
        imm = '0;
        pc = tbPc;
    endtask

    // issue the prepared op, record its expected dnpc
    task automatic sendOp(input xlenT expPc);
        int waitCycles = 0;
        opValid = 1'b1;
        while (!opReady) begin
            @(posedge clk);
            #1;
            waitCycles++;
            if (waitCycles > 100) reportTimeout("opReady stayed low");
        end
        expPcQ.push_back({expPc[63:1], 1'b0});
        tbPc = {expPc[63:1], 1'b0};
        @(posedge clk);
        #1;
        opValid = 1'b0;
    endtask

    task automatic setReg(input regAddrT r, input xlenT val);
        clearFields();
        pc = val;
        aluSrcA = 1'b0;
        aluSrcB = SRCB_IMM;
        rd = r;
        regWen = 1'b1;
        if (r != 0) refRegs[r] = val;
        sendOp(val + 4);
    endtask

    task automatic doAlu(input aluOpT op, input regAddrT d, s1, s2, input logic useImm,
                         input xlenT v);
        clearFields();
        aluOp = op;
        rd = d;
        rs1 = s1;
        rs2 = s2;
        regWen = 1'b1;
        imm = v;
        aluSrcB = useImm ? SRCB_IMM : SRCB_REG;
        if (d != 0) refRegs[d] = refAlu(op, refRegs[s1], useImm ? v : refRegs[s2]);
        sendOp(tbPc + 4);
    endtask

    task automatic doStore(input memOpT op, input regAddrT base, src, input xlenT v);
        xlenT a;
        byteSelT s;
        a = refRegs[base] + v;
        s = byteSelT'(((9'd1 << accessBytes(op)) - 1) << a[2:0]);
        stAdrQ.push_back({a[63:3], 3'b0});
        stSelQ.push_back(s);
        stDatQ.push_back(refRegs[src] << (a[2:0] * 8));
        refMem[{a[63:3], 3'b0}] = (refRead({a[63:3], 3'b0}) & ~byteMask(s)) |
                                  ((refRegs[src] << (a[2:0] * 8)) & byteMask(s));
        clearFields();
        memOp = op;
        rs1 = base;
        rs2 = src;
        aluSrcB = SRCB_IMM;
        imm = v;
        sendOp(tbPc + 4);
    endtask

    task automatic doLoad(input memOpT op, input regAddrT d, base, input xlenT v);
        xlenT a;
        a = refRegs[base] + v;
        if (d != 0) refRegs[d] = refLoad(op, refRead({a[63:3], 3'b0}), a[2:0]);
        clearFields();
        memOp = op;
        rd = d;
        rs1 = base;
        aluSrcB = SRCB_IMM;
        imm = v;
        regWen = 1'b1;
        sendOp(tbPc + 4);
    endtask

    task automatic doBranch(input branchT br, input xlenT v);
        xlenT a, b;
        logic taken;
        a = refRegs[5];
        b = refRegs[6];
        clearFields();
        branch = br;
        rs1 = 5'd5;
        rs2 = 5'd6;
        imm = v;
        case (br)
            BR_BEQ: begin
                aluOp = ALU_SUB;
                taken = (a == b);
            end
            BR_BNE: begin
                aluOp = ALU_SUB;
                taken = (a != b);
            end
            BR_BLT: begin
                aluOp = ALU_SLT;
                taken = ($signed(a) < $signed(b));
            end
            BR_BGE: begin
                aluOp = ALU_SLT;
                taken = !($signed(a) < $signed(b));
            end
            default: begin
                aluSrcA = 1'b0;
                aluSrcB = SRCB_FOUR;
                rd = 5'd7;
                regWen = 1'b1;
                taken = 1'b1;
                refRegs[7] = tbPc + 4;
            end
        endcase
        sendOp((br == BR_JALR) ? a + v : (taken ? tbPc + v : tbPc + 4));
    endtask

    task automatic doCsr(input csrOpT op, input csrAddrT ca, input regAddrT s1, input logic usePc);
        xlenT d, old;
        d = usePc ? tbPc : refRegs[s1];
        old = refCsr.exists(ca) ? refCsr[ca] : '0;
        refRegs[8] = old;
        if (refCsr.exists(ca)) begin
            case (op)
                CSR_WRITE: refCsr[ca] = d;
                CSR_SET:   refCsr[ca] = old | d;
                default:   refCsr[ca] = old & ~d;
            endcase
        end
        clearFields();
        csrOp = op;
        imm = {52'd0, ca};
        rs1 = s1;
        csrSrcPc = usePc;
        csrToReg = 1'b1;
        rd = 5'd8;
        regWen = 1'b1;
        sendOp(tbPc + 4);
    endtask

    initial begin
        memOpT loadOps [7] = '{MEM_LB, MEM_LH, MEM_LW, MEM_LD, MEM_LBU, MEM_LHU, MEM_LWU};
        branchT brOps [6] = '{BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE};
        csrAddrT csrList [5] = '{CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVEC, 12'h7c0};
        int waitCycles = 0;
        void'($urandom(32'h706eb7c1));
        clk = 1'b0;
        arstN = 1'b0;
        opValid = 1'b0;
        wbAck = 1'b0;
        wbDatR = '0;
        tbPc = '0;
        ackWait = 0;
        foreach (refRegs[i]) refRegs[i] = '0;
        refCsr[CSR_MSCRATCH] = '0;
        refCsr[CSR_MEPC] = '0;
        refCsr[CSR_MCAUSE] = '0;
        refCsr[CSR_MTVEC] = '0;
        clearFields();
        repeat (8) @(posedge clk);
        #1 arstN = 1'b1;
        setReg(30, 64'h400);
        setReg(31, 64'h800);
        // alu ops, each result stored through the bus
        for (int i = 1; i < 21; i++) setReg(regAddrT'(i), {$urandom, $urandom});
        for (int i = 0; i < 60; i++) begin
            doAlu(aluOpT'($urandom_range(0, 9)), regAddrT'($urandom_range(1, 20)),
                  regAddrT'($urandom_range(1, 20)), regAddrT'($urandom_range(1, 20)),
                  $urandom_range(0, 1), {$urandom, $urandom});
            doStore(MEM_SD, 30, rd, 0);
        end
        // loads of every width and offset, negative and positive bytes
        for (int w = 0; w < 2; w++) begin
            setReg(12, w ? {$urandom, $urandom} & 64'h7f7f7f7f7f7f7f7f
                         : {$urandom, $urandom} | 64'h8080808080808080);
            doStore(MEM_SD, 31, 12, 0);
            for (int off = 0; off < 8; off++) begin
                foreach (loadOps[k]) begin
                    if (off % accessBytes(loadOps[k]) == 0) begin
                        doLoad(loadOps[k], 10, 31, off);
                        doStore(MEM_SD, 30, 10, 0);
                    end
                end
                doStore(off[0] ? MEM_SB : (off[1] ? MEM_SH : MEM_SW), 31, 12, 8 + off);
            end
            doLoad(MEM_LD, 11, 31, 8);
            doStore(MEM_SD, 30, 11, 0);
        end
        // branches and jumps, taken and not taken
        foreach (brOps[k]) begin
            for (int t = 0; t < 4; t++) begin
                setReg(5, {$urandom, $urandom} | t[0]);
                setReg(6, t[1] ? refRegs[5] : {$urandom, $urandom});
                doBranch(brOps[k], xlenT'($signed(12'($urandom))));
                doStore(MEM_SD, 30, 7, 0);
            end
        end
        // csr write/set/clear, unknown address at 7c0
        foreach (csrList[k]) begin
            doCsr(CSR_WRITE, csrList[k], 5, 1'b0);
            doStore(MEM_SD, 30, 8, 0);
            doCsr(CSR_SET, csrList[k], 6, 1'b0);
            doStore(MEM_SD, 30, 8, 0);
            doCsr(CSR_CLEAR, csrList[k], 5, 1'b0);
            doStore(MEM_SD, 30, 8, 0);
        end
        // ecall path then mret
        doCsr(CSR_WRITE, CSR_MEPC, 0, 1'b1);
        doAlu(ALU_ADD, 9, 5, 6, 1'b0, 0);
        clearFields();
        mret = 1'b1;
        sendOp(refCsr[CSR_MEPC]);
        // x0 stays zero
        setReg(0, {$urandom, $urandom});
        doAlu(ALU_OR, 0, 5, 6, 1'b0, 0);
        doStore(MEM_SD, 30, 0, 0);
        while (expPcQ.size() != 0 || stSelQ.size() != 0) begin
            @(posedge clk);
            waitCycles++;
            if (waitCycles > 200) reportTimeout("ops did not all retire");
        end
        repeat (4) @(posedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- files.f
rvPkg.sv
exuCtrlPkg.sv
regFile.sv
csrFile.sv
alu.sv
nextPc.sv
lsuWishbone.sv
exuTop.sv
exuTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing -j 0
TOP = exuTb
FILELIST = files.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir
